/* Bender.yml */
package:
  name: forget_gate_vector

sources:
  - files:
      - forget_gate_pkg.sv
      - vector_buffer.sv
      - multiply_accumulator.sv
      - logistic_function.sv
      - forget_gate_controller.sv
      - forget_gate_vector.sv
  - target: test
    include_dirs:
      - .
    files:
      - forget_gate_tb.sv

/* files.f */
+incdir+.
forget_gate_pkg.sv
vector_buffer.sv
multiply_accumulator.sv
logistic_function.sv
forget_gate_controller.sv
forget_gate_vector.sv
forget_gate_tb.sv

/* forget_gate_controller.sv */
////////////////////
// Forget gate controller
// Phase FSM, element and row counters, MAC operand routing
////////////////////

`default_nettype none

module forget_gate_controller
  import forget_gate_pkg::*;
#(
  parameter int DATA_SIZE = 16,
  parameter int X_SIZE = 4,
  parameter int R_SIZE = 4,
  parameter int L_SIZE = 3,
  parameter int INDEX_SIZE = 2   // Covers the longest vector
) (
  input  wire                     CLK,
  input  wire                     RST,
  input  wire                     start,
  input  wire                     x_in_enable,
  input  wire                     r_in_enable,
  input  wire                     h_in_enable,
  input  wire                     w_in_enable,
  input  wire                     k_in_enable,
  input  wire                     u_in_enable,
  input  wire                     b_in_enable,
  input  wire  [DATA_SIZE-1:0]    w_in,
  input  wire  [DATA_SIZE-1:0]    k_in,
  input  wire  [DATA_SIZE-1:0]    u_in,
  input  wire  [DATA_SIZE-1:0]    b_in,
  input  wire  [DATA_SIZE-1:0]    x_elem,      // Buffered operands
  input  wire  [DATA_SIZE-1:0]    r_elem,
  input  wire  [DATA_SIZE-1:0]    h_elem,
  output logic                    x_write,
  output logic                    r_write,
  output logic                    h_write,
  output logic [INDEX_SIZE-1:0]   write_index,
  output logic [INDEX_SIZE-1:0]   read_index,
  output logic                    mac_enable,
  output logic [DATA_SIZE-1:0]    mac_weight,
  output logic [DATA_SIZE-1:0]    mac_operand,
  output logic                    bias_enable,
  output logic [DATA_SIZE-1:0]    bias,
  output logic                    last_row,    // Aligned with sum_valid
  output logic                    ready
);

  localparam logic [INDEX_SIZE-1:0] X_LAST = INDEX_SIZE'(X_SIZE - 1);
  localparam logic [INDEX_SIZE-1:0] R_LAST = INDEX_SIZE'(R_SIZE - 1);
  localparam logic [INDEX_SIZE-1:0] L_LAST = INDEX_SIZE'(L_SIZE - 1);

  fg_phase_e               phase;
  fg_phase_e               next_phase;  // Where the phase goes after its last element
  logic [INDEX_SIZE-1:0]   elem;        // Element within vector or row
  logic [INDEX_SIZE-1:0]   row;         // Output row l
  logic [INDEX_SIZE-1:0]   elem_last;   // Final element of current phase
  logic                    take;        // Expected strobe seen

  ////////////////////
  // Strobe decode and routing
  ////////////////////

  always_comb begin
    take        = 1'b0;
    elem_last   = '0;
    next_phase  = IDLE_PHASE;
    x_write     = 1'b0;
    r_write     = 1'b0;
    h_write     = 1'b0;
    mac_enable  = 1'b0;
    mac_weight  = w_in;
    mac_operand = x_elem;
    bias_enable = 1'b0;
    unique case (phase)
      IDLE_PHASE: begin
        take       = start;
        next_phase = LOAD_X_PHASE;
      end
      LOAD_X_PHASE: begin
        take       = x_in_enable;
        x_write    = x_in_enable;
        elem_last  = X_LAST;
        next_phase = LOAD_R_PHASE;
      end
      LOAD_R_PHASE: begin
        take       = r_in_enable;
        r_write    = r_in_enable;
        elem_last  = R_LAST;
        next_phase = LOAD_H_PHASE;
      end
      LOAD_H_PHASE: begin
        take       = h_in_enable;
        h_write    = h_in_enable;
        elem_last  = L_LAST;            // h has L elements
        next_phase = ROW_W_PHASE;
      end
      ROW_W_PHASE: begin
        take       = w_in_enable;
        mac_enable = w_in_enable;       // W(l,x) * x(x)
        elem_last  = X_LAST;
        next_phase = ROW_K_PHASE;
      end
      ROW_K_PHASE: begin
        take        = k_in_enable;
        mac_enable  = k_in_enable;      // K(l,k) * r(k)
        mac_weight  = k_in;
        mac_operand = r_elem;
        elem_last   = R_LAST;
        next_phase  = ROW_U_PHASE;
      end
      ROW_U_PHASE: begin
        take        = u_in_enable;
        mac_enable  = u_in_enable;      // U(l,p) * h(p)
        mac_weight  = u_in;
        mac_operand = h_elem;
        elem_last   = L_LAST;
        next_phase  = ROW_B_PHASE;
      end
      ROW_B_PHASE: begin
        take        = b_in_enable;
        bias_enable = b_in_enable;
        next_phase  = (row == L_LAST) ? IDLE_PHASE : ROW_W_PHASE;
      end
    endcase
  end

  assign bias        = b_in;
  assign write_index = elem;
  assign read_index  = elem;  // Same counter walks the buffer

  ////////////////////
  // Phase and counters
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase    <= IDLE_PHASE;
      elem     <= '0;
      row      <= '0;
      last_row <= 1'b0;
      ready    <= 1'b0;
    end else begin
      last_row <= bias_enable && (row == L_LAST);  // Registered with the bias
      ready    <= last_row;                        // Lines up with f_out_enable
      if (take) begin
        if (elem == elem_last) begin
          elem  <= '0;
          phase <= next_phase;
        end else begin
          elem <= elem + 1'b1;
        end
        if (phase == ROW_B_PHASE) begin
          row <= (row == L_LAST) ? '0 : row + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* forget_gate_pkg.sv */
////////////////////
// Forget gate shared definitions
// Q8.8 format constants and controller phases
////////////////////

`default_nettype none

package forget_gate_pkg;

  ////////////////////
  // Fixed-point format
  ////////////////////

  localparam int FRAC_BITS = 8;     // Q8.8 data words
  localparam int ACC_SIZE = 32;     // Accumulator and row sum width

  // Hard sigmoid constants in Q8.8
  localparam int SIGMOID_HALF = 128;  // 0.5
  localparam int SIGMOID_ONE = 256;   // 1.0

  ////////////////////
  // Controller phases
  ////////////////////

  typedef enum logic [2:0] {
    IDLE_PHASE,    // Waiting for start
    LOAD_X_PHASE,  // Filling x buffer
    LOAD_R_PHASE,  // Filling r buffer
    LOAD_H_PHASE,  // Filling h buffer
    ROW_W_PHASE,   // W row against x
    ROW_K_PHASE,   // K row against r
    ROW_U_PHASE,   // U row against h
    ROW_B_PHASE    // Bias closes the row
  } fg_phase_e;

endpackage

`default_nettype wire

/* forget_gate_model.svh */
////////////////////
// Forget gate reference model
// Floor-scaled products, bias add, hard sigmoid
////////////////////

`ifndef FORGET_GATE_MODEL_SVH
`define FORGET_GATE_MODEL_SVH

// Floor of a/d for positive d
function automatic longint floor_div(input longint a, input longint d);
  longint q;
  q = a / d;                           // Truncates toward zero
  if ((a % d != 0) && (a < 0)) begin
    q = q - 1;
  end
  return q;
endfunction

// Slope 1/4 line through 0.5 clamped to 0..1
function automatic int hard_sigmoid(input longint s);
  longint y;
  y = floor_div(s, 4) + SIGMOID_HALF;
  if (y < 0) begin
    return 0;
  end
  return (y > SIGMOID_ONE) ? SIGMOID_ONE : int'(y);
endfunction

// Expected f(l) from the operand arrays of the testbench
function automatic int expected_row(input int l);
  longint s;
  longint scale;
  scale = longint'(1) << FRAC_BITS;
  s = 0;
  for (int i = 0; i < X_SIZE; i++) s += floor_div(longint'(wv[l][i]) * xv[i], scale);
  for (int i = 0; i < R_SIZE; i++) s += floor_div(longint'(kv[l][i]) * rv[i], scale);
  for (int i = 0; i < L_SIZE; i++) s += floor_div(longint'(uv[l][i]) * hv[i], scale);
  return hard_sigmoid(s + bv[l]);
endfunction

`endif

/* forget_gate_tb.sv */
////////////////////
// Forget gate testbench
// Random jobs against a reference model
////////////////////

`default_nettype none

module forget_gate_tb
  import forget_gate_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_SIZE = 16;
  localparam int X_SIZE = 4;
  localparam int R_SIZE = 4;
  localparam int L_SIZE = 3;
  localparam int MAX_STROBES = 1 + X_SIZE + R_SIZE + L_SIZE
                               + L_SIZE * (X_SIZE + R_SIZE + L_SIZE + 1);
  localparam int NUM_JOBS = 28;       // Random, saturation, back-to-back, slow
  localparam int LONG_JOBS = 2;
  localparam int LONG_GAP = 12;
  localparam int LIMIT_CYCLES = NUM_JOBS * MAX_STROBES * 5
                                + LONG_JOBS * MAX_STROBES * LONG_GAP + 200;

  logic                 CLK, RST;
  logic [7:0]           en;            // start, x, r, h, w, k, u, b
  logic [DATA_SIZE-1:0] data_in [8];   // Word per strobe with slot 0 unused
  logic                 ready, f_out_enable;
  logic [DATA_SIZE-1:0] f_out;

  int xv[X_SIZE], rv[R_SIZE], hv[L_SIZE], bv[L_SIZE];
  int wv[L_SIZE][X_SIZE], kv[L_SIZE][R_SIZE], uv[L_SIZE][L_SIZE];
  int exp_q[$];                        // Rows not yet seen on f_out
  int words, jobs_sent, jobs_done;

  `include "forget_gate_model.svh"

  forget_gate_vector #(.DATA_SIZE(DATA_SIZE), .X_SIZE(X_SIZE), .R_SIZE(R_SIZE),
                       .L_SIZE(L_SIZE)) dut (
    .CLK, .RST, .start(en[0]),
    .x_in_enable(en[1]), .x_in(data_in[1]), .r_in_enable(en[2]), .r_in(data_in[2]),
    .h_in_enable(en[3]), .h_in(data_in[3]), .w_in_enable(en[4]), .w_in(data_in[4]),
    .k_in_enable(en[5]), .k_in(data_in[5]), .u_in_enable(en[6]), .u_in(data_in[6]),
    .b_in_enable(en[7]), .b_in(data_in[7]), .ready, .f_out_enable, .f_out
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  ////////////////////
  // Reporting
  ////////////////////

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "Stopping at first failure");
  endtask

  task automatic check(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
      abort_run();
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic int pick(input int sat, input bit weight);
    if (sat == 0) begin
      return int'($urandom_range(1024)) - 512;   // -2.0 .. +2.0
    end
    if (!weight) begin
      return 512;
    end
    return (sat == 1) ? 512 : -512;              // Drive to a rail
  endfunction

  // Junk strobes on every operand except the expected one
  task automatic scatter_junk(input int kind, input bit noisy);
    en = noisy ? (8'($urandom) & ~(8'b1 << kind)) : 8'h00;
    for (int i = 1; i < 8; i++) begin
      if (noisy && i != kind) data_in[i] = DATA_SIZE'($urandom);
    end
  endtask

  task automatic drive_strobe(input int kind, input int value, input bit noisy,
                              input int gap_min, input int gap_max);
    int gap;
    gap = gap_min + int'($urandom_range(gap_max - gap_min));
    repeat (gap) begin
      scatter_junk(kind, noisy);
      @(negedge CLK);
    end
    scatter_junk(kind, noisy);
    en[kind] = 1'b1;
    data_in[kind] = DATA_SIZE'(value);
    @(negedge CLK);
    en = 8'h00;
  endtask

  task automatic run_job(input int sat, input bit noisy, input int gap_min, input int gap_max);
    int e;
    foreach (xv[i]) xv[i] = pick(sat, 1'b0);
    foreach (rv[i]) rv[i] = pick(sat, 1'b0);
    foreach (hv[i]) hv[i] = pick(sat, 1'b0);
    foreach (wv[l, i]) wv[l][i] = pick(sat, 1'b1);
    foreach (kv[l, i]) kv[l][i] = pick(sat, 1'b1);
    foreach (uv[l, i]) uv[l][i] = pick(sat, 1'b1);
    foreach (bv[l]) bv[l] = pick(sat, 1'b1);
    for (int l = 0; l < L_SIZE; l++) begin
      if (sat == 0) begin
        e = expected_row(l);
      end else begin
        e = (sat == 1) ? SIGMOID_ONE : 0;  // Upper or lower rail
      end
      exp_q.push_back(e);
    end
    drive_strobe(0, 0, noisy, gap_min, gap_max);
    foreach (xv[i]) drive_strobe(1, xv[i], noisy, gap_min, gap_max);
    foreach (rv[i]) drive_strobe(2, rv[i], noisy, gap_min, gap_max);
    foreach (hv[i]) drive_strobe(3, hv[i], noisy, gap_min, gap_max);
    for (int l = 0; l < L_SIZE; l++) begin
      foreach (xv[i]) drive_strobe(4, wv[l][i], noisy, gap_min, gap_max);
      foreach (rv[i]) drive_strobe(5, kv[l][i], noisy, gap_min, gap_max);
      foreach (hv[i]) drive_strobe(6, uv[l][i], noisy, gap_min, gap_max);
      drive_strobe(7, bv[l], noisy, gap_min, gap_max);
    end
    jobs_sent++;
  endtask

  ////////////////////
  // Output monitor
  ////////////////////

  always @(negedge CLK) begin
    if (!RST && f_out_enable) begin
      if (exp_q.size() == 0) begin
        $display("An output word appeared with no row outstanding");
        abort_run();
      end else begin
        words++;
        check("f_out", exp_q.pop_front(), f_out);
        check("ready_on_last_row", words == L_SIZE, ready);  // One READY per job
        if (words == L_SIZE) begin
          words = 0;
          jobs_done++;
        end
      end
    end else if (!RST) begin
      check("ready_without_f_out", 0, ready);
    end
  end

  // Watchdog
  initial begin
    #(LIMIT_CYCLES * 40);
    $display("The run took too long and did not finish all jobs");
    abort_run();
  end

  initial begin
    void'($urandom(69396));
    RST = 1'b1;
    en = 8'h00;
    foreach (data_in[i]) data_in[i] = '0;
    words = 0;
    jobs_sent = 0;
    jobs_done = 0;
    repeat (3) @(negedge CLK);
    RST = 1'b0;
    check("ready_after_reset", 0, ready);
    check("f_out_enable_after_reset", 0, f_out_enable);
    check("f_out_after_reset", 0, f_out);
    repeat (5) @(negedge CLK);  // Idle cycles where any output is an error

    for (int j = 0; j < 20; j++) run_job(0, j % 2, 0, 3);  // Odd jobs get junk strobes
    run_job(1, 1'b1, 0, 3);
    run_job(2, 1'b0, 0, 3);

    // START in the READY cycle
    for (int j = 0; j < 4; j++) begin
      while (!ready) @(negedge CLK);
      run_job(0, 1'b0, 0, 0);
    end
    for (int j = 0; j < LONG_JOBS; j++) run_job(0, 1'b0, 4, LONG_GAP);

    wait (jobs_done == jobs_sent);
    repeat (4) @(negedge CLK);  // Trailing words would trip the monitor
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

/* forget_gate_vector.sv */
////////////////////
// Forget gate vector top level
// f = sigmoid(W*x + K*r + U*h + b), one word per row
////////////////////

`default_nettype none

module forget_gate_vector
  import forget_gate_pkg::*;
#(
  parameter int DATA_SIZE = 16,
  parameter int X_SIZE = 4,
  parameter int R_SIZE = 4,
  parameter int L_SIZE = 3
) (
  input  wire                   CLK,
  input  wire                   RST,
  input  wire                   start,
  input  wire                   x_in_enable,
  input  wire  [DATA_SIZE-1:0]  x_in,
  input  wire                   r_in_enable,
  input  wire  [DATA_SIZE-1:0]  r_in,
  input  wire                   h_in_enable,
  input  wire  [DATA_SIZE-1:0]  h_in,
  input  wire                   w_in_enable,
  input  wire  [DATA_SIZE-1:0]  w_in,
  input  wire                   k_in_enable,
  input  wire  [DATA_SIZE-1:0]  k_in,
  input  wire                   u_in_enable,
  input  wire  [DATA_SIZE-1:0]  u_in,
  input  wire                   b_in_enable,
  input  wire  [DATA_SIZE-1:0]  b_in,
  output logic                  ready,
  output logic                  f_out_enable,
  output logic [DATA_SIZE-1:0]  f_out
);

  // Controller counter spans the longest vector
  localparam int MAX_SIZE = (X_SIZE > R_SIZE) ? ((X_SIZE > L_SIZE) ? X_SIZE : L_SIZE)
                                              : ((R_SIZE > L_SIZE) ? R_SIZE : L_SIZE);
  localparam int INDEX_SIZE = $clog2(MAX_SIZE);
  localparam int X_INDEX = $clog2(X_SIZE);
  localparam int R_INDEX = $clog2(R_SIZE);
  localparam int L_INDEX = $clog2(L_SIZE);

  logic                        x_write, r_write, h_write;
  logic [INDEX_SIZE-1:0]       write_index;
  logic [INDEX_SIZE-1:0]       read_index;
  logic [DATA_SIZE-1:0]        x_elem, r_elem, h_elem;
  logic                        mac_enable, bias_enable;
  logic [DATA_SIZE-1:0]        mac_weight, mac_operand, bias;
  logic signed [ACC_SIZE-1:0]  sum;
  logic                        sum_valid;

  forget_gate_controller #(
    .DATA_SIZE(DATA_SIZE), .X_SIZE(X_SIZE), .R_SIZE(R_SIZE), .L_SIZE(L_SIZE),
    .INDEX_SIZE(INDEX_SIZE)
  ) controller (
    .CLK, .RST, .start,
    .x_in_enable, .r_in_enable, .h_in_enable,
    .w_in_enable, .k_in_enable, .u_in_enable, .b_in_enable,
    .w_in, .k_in, .u_in, .b_in,
    .x_elem, .r_elem, .h_elem,
    .x_write, .r_write, .h_write, .write_index, .read_index,
    .mac_enable, .mac_weight, .mac_operand, .bias_enable, .bias,
    .last_row(),  // Internal to READY timing
    .ready
  );

  ////////////////////
  // Operand buffers
  ////////////////////

  vector_buffer #(.DATA_SIZE(DATA_SIZE), .DEPTH(X_SIZE)) x_buffer (
    .CLK, .RST, .write(x_write), .write_index(write_index[X_INDEX-1:0]),
    .write_data(x_in), .read_index(read_index[X_INDEX-1:0]), .read_data(x_elem)
  );

  vector_buffer #(.DATA_SIZE(DATA_SIZE), .DEPTH(R_SIZE)) r_buffer (
    .CLK, .RST, .write(r_write), .write_index(write_index[R_INDEX-1:0]),
    .write_data(r_in), .read_index(read_index[R_INDEX-1:0]), .read_data(r_elem)
  );

  vector_buffer #(.DATA_SIZE(DATA_SIZE), .DEPTH(L_SIZE)) h_buffer (
    .CLK, .RST, .write(h_write), .write_index(write_index[L_INDEX-1:0]),
    .write_data(h_in), .read_index(read_index[L_INDEX-1:0]), .read_data(h_elem)
  );

  // Shared MAC then hard sigmoid
  multiply_accumulator #(.DATA_SIZE(DATA_SIZE)) mac (
    .CLK, .RST, .mac_enable, .weight(mac_weight), .operand(mac_operand),
    .bias_enable, .bias, .sum, .sum_valid
  );

  logistic_function #(.DATA_SIZE(DATA_SIZE)) logistic (
    .CLK, .RST, .sum_valid, .sum, .f_out, .f_out_enable
  );

endmodule

`default_nettype wire

/* logistic_function.sv */
////////////////////
// Hard sigmoid stage
// sum/4 + 0.5, clamped to 0..1 in Q8.8
////////////////////

`default_nettype none

module logistic_function
  import forget_gate_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire                          sum_valid,
  input  wire signed [ACC_SIZE-1:0]    sum,
  output logic [DATA_SIZE-1:0]         f_out,
  output logic                         f_out_enable
);

  logic signed [ACC_SIZE-1:0] linear;  // Unclamped slope line

  assign linear = (sum >>> 2) + ACC_SIZE'(SIGMOID_HALF);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      f_out        <= '0;
      f_out_enable <= 1'b0;
    end else begin
      f_out_enable <= sum_valid;  // One stage behind the row sum
      if (sum_valid) begin
        if (linear < 0) begin
          f_out <= '0;                          // Lower rail
        end else if (linear > SIGMOID_ONE) begin
          f_out <= DATA_SIZE'(SIGMOID_ONE);     // Upper rail
        end else begin
          f_out <= DATA_SIZE'(linear);
        end
      end
    end
  end

endmodule

`default_nettype wire

/* multiply_accumulator.sv */
////////////////////
// Multiply-accumulate unit
// Q8.8 products summed per row, bias closes the row
////////////////////

`default_nettype none

module multiply_accumulator
  import forget_gate_pkg::*;
#(
  parameter int DATA_SIZE = 16
) (
  input  wire                          CLK,
  input  wire                          RST,
  input  wire                          mac_enable,   // Product strobe
  input  wire  [DATA_SIZE-1:0]         weight,
  input  wire  [DATA_SIZE-1:0]         operand,
  input  wire                          bias_enable,  // Row end strobe
  input  wire  [DATA_SIZE-1:0]         bias,
  output logic signed [ACC_SIZE-1:0]   sum,
  output logic                         sum_valid
);

  logic signed [2*DATA_SIZE-1:0] product;  // Full precision product
  logic signed [ACC_SIZE-1:0]    scaled;   // Back to Q8.8 scale
  logic signed [ACC_SIZE-1:0]    bias_ext;
  logic signed [ACC_SIZE-1:0]    acc;      // Running row sum

  ////////////////////
  // Arithmetic
  ////////////////////

  assign product = $signed(weight) * $signed(operand);
  assign scaled = ACC_SIZE'(product >>> FRAC_BITS);  // Floor shift
  assign bias_ext = ACC_SIZE'($signed(bias));         // Sign extend

  // Accumulator and valid flag
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= bias_enable;
      if (bias_enable) begin
        acc <= '0;                 // Next row starts clean
      end else if (mac_enable) begin
        acc <= acc + scaled;
      end
    end
  end

  // Row sum register
  always_ff @(posedge CLK) begin
    if (bias_enable) begin
      sum <= acc + bias_ext;
    end
  end

endmodule

`default_nettype wire

/* vector_buffer.sv */
////////////////////
// Vector buffer
// Strobe-written register file, combinational read
////////////////////

`default_nettype none

module vector_buffer #(
  parameter int DATA_SIZE = 16,
  parameter int DEPTH = 4
) (
  input  wire                         CLK,
  input  wire                         RST,
  input  wire                         write,        // One element this cycle
  input  wire  [$clog2(DEPTH)-1:0]    write_index,
  input  wire  [DATA_SIZE-1:0]        write_data,
  input  wire  [$clog2(DEPTH)-1:0]    read_index,
  output logic [DATA_SIZE-1:0]        read_data
);

  logic [DATA_SIZE-1:0] mem [DEPTH];  // Stored vector

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (write) begin
      mem[write_index] <= write_data;
    end
  end

  // Zero-latency read port
  assign read_data = mem[read_index];

endmodule

`default_nettype wire
